//--- proc_top.f
+incdir+.
proc_pkg.sv
alu.sv
regfile.sv
fetch_unit.sv
hazard_unit.sv
execute_unit.sv
mem_wb_unit.sv
proc_top.sv
proc_tb_clock.sv
proc_top_assert.sv
proc_tb.sv

//--- Bender.yml
package:
  name: proc_top

export_include_dirs:
  - .

sources:
  - proc_pkg.sv
  - alu.sv
  - regfile.sv
  - fetch_unit.sv
  - hazard_unit.sv
  - execute_unit.sv
  - mem_wb_unit.sv
  - proc_top.sv
  - target: test
    files:
      - proc_tb_clock.sv
      - proc_top_assert.sv
      - proc_tb.sv

//--- proc_tb.sv
// Directed programs end in a self-jump; only 256-word instruction and data memories are modelled
`timescale 1ns/1ns
`default_nettype none

`include "proc_macros.svh"

module proc_tb import proc_pkg::*; ();

    logic    clock;
    logic    rst;
    logic    restart;
    word_t   imem_addr;
    word_t   imem_data;
    wb_req_t dmem_req;
    wb_rsp_t dmem_rsp;

    word_t   imem [0:255];
    word_t   dmem [0:255];
    word_t   prog[$];
    word_t   exp_adr[$];
    word_t   exp_dat[$];
    word_t   log_adr[$];
    word_t   log_dat[$];
    int      exp_reads;
    int      log_reads;
    int      ack_mode;         // Ack delay in cycles or -1 for random
    int      wait_left;
    logic    waiting;
    int      errors;
    int      test_errors;
    int      tests_run;

    proc_tb_clock u_clock (
        .restart (restart),
        .clock   (clock),
        .rst     (rst)
    );

    proc_top u_dut (
        .clock     (clock),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .dmem_req  (dmem_req),
        .dmem_rsp  (dmem_rsp)
    );

    assign imem_data = imem[imem_addr[7:0]];   // Combinational ROM

    // Wishbone slave driven on the falling edge
    always @(negedge clock) begin
        if (rst) begin
            dmem_rsp = '0;
            waiting  = 1'b0;
        end else if (dmem_rsp.ack) begin
            dmem_rsp.ack = 1'b0;                 // Transfer closed at the last rising edge
        end else if (dmem_req.cyc && dmem_req.stb) begin
            if (!waiting) begin
                waiting   = 1'b1;
                wait_left = (ack_mode < 0) ? $urandom_range(3, 0) : ack_mode;
            end
            if (wait_left == 0) begin
                waiting      = 1'b0;
                dmem_rsp.ack = 1'b1;
                if (dmem_req.we) begin
                    dmem[dmem_req.adr[7:0]] = dmem_req.dat;
                    log_adr.push_back(dmem_req.adr);
                    log_dat.push_back(dmem_req.dat);
                end else begin
                    dmem_rsp.dat = dmem[dmem_req.adr[7:0]];
                    log_reads++;
                end
            end else begin
                wait_left--;
            end
        end
    end

    // Instruction encoders
    function automatic word_t enc_r(logic [4:0] op, logic [4:0] rd, logic [4:0] rs,
                                    logic [4:0] rt, logic [4:0] sh);
        return {`PROC_OP_RTYPE, rd, rs, rt, sh, op, 2'b00};
    endfunction

    function automatic word_t enc_i(logic [4:0] opc, logic [4:0] rd, logic [4:0] rs,
                                    int imm);
        logic [16:0] imm17;
        imm17 = imm[16:0];
        return {opc, rd, rs, imm17};
    endfunction

    function automatic word_t enc_j(logic [4:0] opc, int tgt);
        logic [26:0] t27;
        t27 = tgt[26:0];
        return {opc, t27};
    endfunction

    function automatic void expect_store(int adr, word_t dat);
        exp_adr.push_back(word_t'(adr));
        exp_dat.push_back(dat);
    endfunction

    function automatic void clear_prog();
        prog.delete();
        exp_adr.delete();
        exp_dat.delete();
        exp_reads = 0;
    endfunction

    // Dependent chain over every ALU operation
    task automatic load_alu();
        word_t a, b, c, d, e, f, g, h, k;
        clear_prog();
        prog.push_back(enc_i(`PROC_OP_ADDI, 1, 0, 5));
        prog.push_back(enc_i(`PROC_OP_ADDI, 2, 1, 7));
        prog.push_back(enc_r(`PROC_ALU_ADD, 3, 2, 1, 0));
        prog.push_back(enc_r(`PROC_ALU_SUB, 4, 3, 2, 0));
        prog.push_back(enc_r(`PROC_ALU_AND, 5, 4, 3, 0));
        prog.push_back(enc_r(`PROC_ALU_OR, 6, 5, 4, 0));
        prog.push_back(enc_r(`PROC_ALU_SLL, 7, 6, 0, 3));
        prog.push_back(enc_i(`PROC_OP_ADDI, 8, 0, -64));
        prog.push_back(enc_r(`PROC_ALU_SRA, 9, 8, 0, 2));
        for (int r = 2; r <= 9; r++) begin
            prog.push_back(enc_i(`PROC_OP_SW, r, 0, 14 + r));   // Stores at 16..23
        end
        prog.push_back(enc_j(`PROC_OP_J, prog.size()));
        a = 5;
        b = a + 7;
        c = b + a;
        d = c - b;
        e = d & c;
        f = e | d;              // 1 | 5 differs from 1 + 5
        g = f * 8;
        h = -64;
        k = $signed(h) / 4;     // Exact multiple of 4 so sign-filled
        expect_store(16, b);
        expect_store(17, c);
        expect_store(18, d);
        expect_store(19, e);
        expect_store(20, f);
        expect_store(21, g);
        expect_store(22, h);
        expect_store(23, k);
    endtask

    // lw feeding the very next instruction
    task automatic load_load_use();
        clear_prog();
        prog.push_back(enc_i(`PROC_OP_ADDI, 1, 0, 40));
        prog.push_back(enc_i(`PROC_OP_LW, 2, 1, 0));
        prog.push_back(enc_i(`PROC_OP_ADDI, 3, 2, 9));
        prog.push_back(enc_r(`PROC_ALU_ADD, 4, 3, 2, 0));
        prog.push_back(enc_i(`PROC_OP_SW, 3, 0, 50));
        prog.push_back(enc_i(`PROC_OP_SW, 4, 0, 51));
        prog.push_back(enc_j(`PROC_OP_J, 6));
        exp_reads = 1;
        expect_store(50, 123 + 9);
        expect_store(51, 123 + 9 + 123);
    endtask

    // bne and blt both ways with stores on the skipped paths
    task automatic load_branch();
        clear_prog();
        prog.push_back(enc_i(`PROC_OP_ADDI, 1, 0, 3));     // 0
        prog.push_back(enc_i(`PROC_OP_ADDI, 2, 0, 3));     // 1
        prog.push_back(enc_i(`PROC_OP_BNE, 1, 2, 1));      // 2 not taken with both bypassed
        prog.push_back(enc_i(`PROC_OP_SW, 1, 0, 60));      // 3
        prog.push_back(enc_i(`PROC_OP_ADDI, 2, 0, 4));     // 4
        prog.push_back(enc_i(`PROC_OP_BNE, 2, 1, 2));      // 5 taken to 8
        prog.push_back(enc_i(`PROC_OP_SW, 2, 0, 61));      // 6 skipped
        prog.push_back(enc_i(`PROC_OP_SW, 2, 0, 62));      // 7 skipped
        prog.push_back(enc_i(`PROC_OP_SW, 1, 0, 63));      // 8
        prog.push_back(enc_i(`PROC_OP_ADDI, 3, 0, -1));    // 9
        prog.push_back(enc_i(`PROC_OP_BLT, 3, 1, 1));      // 10 taken to 12 as -1 < 3
        prog.push_back(enc_i(`PROC_OP_SW, 3, 0, 64));      // 11 skipped
        prog.push_back(enc_i(`PROC_OP_BLT, 1, 3, 1));      // 12 not taken
        prog.push_back(enc_i(`PROC_OP_SW, 3, 0, 65));      // 13
        prog.push_back(enc_j(`PROC_OP_J, 14));
        expect_store(60, 3);
        expect_store(63, 3);
        expect_store(65, -1);
    endtask

    // jal into a subroutine and jr back
    task automatic load_jump();
        clear_prog();
        prog.push_back(enc_j(`PROC_OP_JAL, 5));            // 0
        prog.push_back(enc_i(`PROC_OP_SW, 31, 0, 70));     // 1 return point
        prog.push_back(enc_j(`PROC_OP_J, 10));             // 2
        prog.push_back(enc_i(`PROC_OP_SW, 31, 0, 71));     // 3 slot
        prog.push_back(enc_i(`PROC_OP_SW, 31, 0, 72));     // 4 slot
        prog.push_back(enc_i(`PROC_OP_ADDI, 5, 0, 9));     // 5
        prog.push_back(enc_i(`PROC_OP_SW, 5, 0, 73));      // 6
        prog.push_back(enc_i(`PROC_OP_JR, 31, 0, 0));      // 7
        prog.push_back(enc_i(`PROC_OP_SW, 5, 0, 74));      // 8 slot
        prog.push_back(enc_i(`PROC_OP_SW, 5, 0, 75));      // 9 slot
        prog.push_back(enc_j(`PROC_OP_J, 10));
        expect_store(73, 9);
        expect_store(70, 0 + 1);   // jal PC plus one
    endtask

    // Store data produced just before and a store of r0
    task automatic load_store_data();
        clear_prog();
        prog.push_back(enc_i(`PROC_OP_ADDI, 1, 0, 77));
        prog.push_back(enc_i(`PROC_OP_SW, 1, 0, 80));
        prog.push_back(enc_i(`PROC_OP_ADDI, 0, 0, 5));
        prog.push_back(enc_i(`PROC_OP_SW, 0, 0, 81));
        prog.push_back(enc_i(`PROC_OP_LW, 2, 0, 40));
        prog.push_back(enc_i(`PROC_OP_SW, 2, 0, 82));
        prog.push_back(enc_j(`PROC_OP_J, 6));
        exp_reads = 1;
        expect_store(80, 77);
        expect_store(81, 0);
        expect_store(82, 123);
    endtask

    // Reset and load, then run to the self-jump and compare the store log
    task automatic run_check(string name, int mode);
        int cycles;
        int limit;
        int entries;
        word_t halt_pc;
        word_t prev_addr;
        test_errors = 0;
        ack_mode    = mode;
        @(negedge clock);
        restart = 1'b1;
        @(negedge clock);
        restart = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = enc_j(`PROC_OP_J, i);              // Stray fetches stay put
            dmem[i] = {i[15:0], ~i[15:0]};
        end
        dmem[40] = 123;
        foreach (prog[i]) imem[i] = prog[i];
        halt_pc = prog.size() - 1;
        log_adr.delete();
        log_dat.delete();
        log_reads = 0;
        while (rst) @(negedge clock);
        limit     = prog.size() * 12 + 40;              // Worst case 3-cycle acks and flushes
        cycles    = 0;
        entries   = 0;
        prev_addr = '1;
        while (entries < 3) begin
            @(negedge clock);
            cycles++;
            if (imem_addr == halt_pc && prev_addr != halt_pc) entries++;
            prev_addr = imem_addr;
            if (cycles > limit) begin
                $display("Checks failed");
                $display("timeout in %s after %0d cycles, program never reached its halt",
                         name, cycles);
                $finish;
            end
        end
        assert (log_adr.size() == exp_adr.size()) else begin
            $display("error %0t store count: got %0d expected %0d",
                     $time, log_adr.size(), exp_adr.size());
            test_errors++;
        end
        assert (log_reads == exp_reads) else begin
            $display("error %0t read count: got %0d expected %0d",
                     $time, log_reads, exp_reads);
            test_errors++;
        end
        for (int i = 0; i < exp_adr.size() && i < log_adr.size(); i++) begin
            assert (log_adr[i] == exp_adr[i]) else begin
                $display("error %0t dmem_req.adr[%0d]: got %0d expected %0d",
                         $time, i, log_adr[i], exp_adr[i]);
                test_errors++;
            end
            assert (log_dat[i] == exp_dat[i]) else begin
                $display("error %0t dmem_req.dat[%0d]: got %h expected %h",
                         $time, i, log_dat[i], exp_dat[i]);
                test_errors++;
            end
        end
        errors += test_errors;
        tests_run++;
        $display("%s (ack %0d): %0d errors", name, mode, test_errors);
    endtask

    task automatic test_alu_bypass();
        load_alu();
        run_check("alu bypass", -1);
    endtask

    task automatic test_load_use();
        load_load_use();
        run_check("load use", -1);
    endtask

    task automatic test_branches();
        load_branch();
        run_check("branches", -1);
    endtask

    task automatic test_jumps();
        load_jump();
        run_check("jumps", -1);
    endtask

    task automatic test_store_data();
        load_store_data();
        run_check("store data", -1);
    endtask

    // Same logs with fastest and slowest slave
    task automatic test_ack_delays();
        int modes [2];
        modes = '{0, 3};
        foreach (modes[m]) begin
            load_alu();
            run_check("alu bypass", modes[m]);
            load_load_use();
            run_check("load use", modes[m]);
            load_branch();
            run_check("branches", modes[m]);
            load_jump();
            run_check("jumps", modes[m]);
            load_store_data();
            run_check("store data", modes[m]);
        end
    endtask

    initial begin
        void'($urandom(54313));
        restart   = 1'b0;
        dmem_rsp  = '0;
        waiting   = 1'b0;
        wait_left = 0;
        ack_mode  = -1;
        errors    = 0;
        tests_run = 0;
        test_alu_bypass();
        test_load_use();
        test_branches();
        test_jumps();
        test_store_data();
        test_ack_delays();
        $display("%0d runs, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- proc_top_assert.sv
// Wishbone classic rules on the data port; bound into every proc_top instance
`timescale 1ns/1ns
`default_nettype none

module proc_top_assert import proc_pkg::*; (
    input logic    clock,
    input logic    rst,
    input wb_req_t dmem_req,
    input wb_rsp_t dmem_rsp
);

    // Strobe only inside a cycle
    stb_in_cyc: assert property (@(posedge clock) disable iff (rst)
        dmem_req.stb |-> dmem_req.cyc)
        else $error("dmem stb without cyc");

    // Request frozen until the slave acks
    req_stable: assert property (@(posedge clock) disable iff (rst)
        (dmem_req.stb && !dmem_rsp.ack) |=> $stable(dmem_req))
        else $error("dmem request changed while waiting for ack");

    // Nothing on the bus right after reset
    idle_after_rst: assert property (@(posedge clock)
        rst |=> !dmem_req.stb)
        else $error("dmem stb in the cycle after reset");

endmodule

bind proc_top proc_top_assert u_assert (
    .clock    (clock),
    .rst      (rst),
    .dmem_req (dmem_req),
    .dmem_rsp (dmem_rsp)
);

`default_nettype wire

//--- proc_tb_clock.sv
// Free-running 8 ns clock; rst is high for 2 cycles at start and after every restart pulse
`timescale 1ns/1ns
`default_nettype none

module proc_tb_clock (
    input  logic restart,   // Sampled on the rising edge
    output logic clock,
    output logic rst
);

    logic [1:0] rst_cnt = 2'd2;   // Power-on reset

    initial clock = 1'b0;
    always #4 clock = ~clock;

    always @(posedge clock) begin
        if (restart) begin
            rst_cnt <= 2'd2;
        end else if (rst_cnt != 2'd0) begin
            rst_cnt <= rst_cnt - 2'd1;
        end
    end

    assign rst = rst_cnt != 2'd0;

endmodule

`default_nettype wire

//--- proc_top.sv
// Core top; imem must answer in the same cycle, dmem is a Wishbone classic slave that may stall with ack
`timescale 1ns/1ns
`default_nettype none

`include "proc_macros.svh"

module proc_top import proc_pkg::*; (
    input  logic                 clock,
    input  logic                 rst,
    output logic [`PROC_XLEN-1:0] imem_addr,   // Word address
    input  logic [`PROC_XLEN-1:0] imem_data,
    output wb_req_t              dmem_req,
    input  wb_rsp_t              dmem_rsp
);

    logic      fd_valid;
    word_t     fd_pc;
    word_t     fd_word;
    inst_dec_t fd_dec;
    reg_idx_t  rd_idx_a;
    reg_idx_t  rd_idx_b;
    word_t     rd_data_a;
    word_t     rd_data_b;
    stage_t    dx;
    stage_t    xm;
    wr_port_t  wr;
    byp_sel_t  byp_sel;
    logic      load_stall;
    logic      mem_busy;
    logic      fetch_hold;
    logic      redirect_taken;
    word_t     redirect_pc;

    assign fetch_hold = load_stall | mem_busy;   // PC and fetch/decode freeze

    fetch_unit u_fetch (
        .clock          (clock),
        .rst            (rst),
        .hold           (fetch_hold),
        .redirect_taken (redirect_taken),
        .redirect_pc    (redirect_pc),
        .imem_addr      (imem_addr),
        .imem_data      (imem_data),
        .fd_valid       (fd_valid),
        .fd_pc          (fd_pc),
        .fd_word        (fd_word)
    );

    regfile u_regfile (
        .clock     (clock),
        .rst       (rst),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr        (wr)
    );

    // Execute stalls only on the memory stage, load_stall is applied inside as a bubble
    execute_unit u_execute (
        .clock          (clock),
        .rst            (rst),
        .hold           (mem_busy),
        .fd_valid       (fd_valid),
        .fd_pc          (fd_pc),
        .fd_word        (fd_word),
        .rd_idx_a       (rd_idx_a),
        .rd_idx_b       (rd_idx_b),
        .rd_data_a      (rd_data_a),
        .rd_data_b      (rd_data_b),
        .fd_dec         (fd_dec),
        .load_stall     (load_stall),
        .byp_sel        (byp_sel),
        .wr             (wr),
        .dx             (dx),
        .xm             (xm),
        .redirect_taken (redirect_taken),
        .redirect_pc    (redirect_pc)
    );

    hazard_unit u_hazard (
        .fd_dec     (fd_dec),
        .fd_valid   (fd_valid),
        .dx         (dx),
        .xm         (xm),
        .wr         (wr),
        .load_stall (load_stall),
        .byp_sel    (byp_sel)
    );

    mem_wb_unit u_mem_wb (
        .clock    (clock),
        .rst      (rst),
        .xm       (xm),
        .dmem_req (dmem_req),
        .dmem_rsp (dmem_rsp),
        .mem_busy (mem_busy),
        .wr       (wr)
    );

endmodule

`default_nettype wire

//--- mem_wb_unit.sv
// Wishbone classic master, one transfer per lw/sw, request held from the stage register until ack
`timescale 1ns/1ns
`default_nettype none

`include "proc_macros.svh"

module mem_wb_unit import proc_pkg::*; (
    input  logic     clock,
    input  logic     rst,
    input  stage_t   xm,
    output wb_req_t  dmem_req,
    input  wb_rsp_t  dmem_rsp,
    output logic     mem_busy,
    output wr_port_t wr
);

    logic   is_mem;
    logic   is_sw;
    word_t  st_data;
    stage_t mw;
    word_t  ld_q;

    assign is_mem = xm.valid &&
                    (xm.dec.opcode == `PROC_OP_LW || xm.dec.opcode == `PROC_OP_SW);
    assign is_sw  = xm.dec.opcode == `PROC_OP_SW;

    // Store data from the instruction now in writeback
    assign st_data = (wr.we && wr.idx == xm.dec.rb) ? wr.data : xm.sdata;

    // Request straight from execute/memory, stable while it holds
    always_comb begin
        dmem_req.cyc = is_mem;
        dmem_req.stb = is_mem;
        dmem_req.we  = is_mem && is_sw;
        dmem_req.adr = xm.res;
        dmem_req.dat = st_data;
    end

    assign mem_busy = is_mem && !dmem_rsp.ack;   // Ends on ack

    // Memory/writeback register
    always_ff @(posedge clock) begin
        if (rst) begin
            mw.valid <= 1'b0;
        end else if (!mem_busy) begin
            mw <= xm;
        end
    end

    // Load data sampled on ack only
    always_ff @(posedge clock) begin
        if (is_mem && !is_sw && dmem_rsp.ack) begin
            ld_q <= dmem_rsp.dat;
        end
    end

    // Write-back selection
    always_comb begin
        wr.we   = mw.valid && mw.dec.rd_we;
        wr.idx  = mw.dec.rd;
        wr.data = (mw.dec.opcode == `PROC_OP_LW) ? ld_q : mw.res;   // jal carries PC + 1
    end

endmodule

`default_nettype wire

//--- execute_unit.sv
// Decode and execute; branches resolve here so a taken one squashes two slots, no redirect while hold is high
`timescale 1ns/1ns
`default_nettype none

`include "proc_macros.svh"

module execute_unit import proc_pkg::*; (
    input  logic      clock,
    input  logic      rst,
    input  logic      hold,            // Memory stage stall
    input  logic      fd_valid,
    input  word_t     fd_pc,
    input  word_t     fd_word,
    output reg_idx_t  rd_idx_a,
    output reg_idx_t  rd_idx_b,
    input  word_t     rd_data_a,
    input  word_t     rd_data_b,
    output inst_dec_t fd_dec,
    input  logic      load_stall,
    input  byp_sel_t  byp_sel,
    input  wr_port_t  wr,
    output stage_t    dx,
    output stage_t    xm,
    output logic      redirect_taken,
    output word_t     redirect_pc
);

    logic [4:0] f_opc;
    reg_idx_t   f_rd;
    reg_idx_t   f_rs;
    reg_idx_t   f_rt;
    logic       f_br;
    logic [4:0] x_opc;
    logic       x_rtype;
    logic       x_br;
    word_t      byp_a;
    word_t      byp_b;
    word_t      op_a;
    word_t      op_b;
    logic [4:0] alu_op;
    word_t      alu_res;
    logic       not_equal;
    logic       less_than;
    logic       taken;

    // Field split of the fetched word
    assign f_opc = fd_word[31:27];
    assign f_rd  = fd_word[26:22];
    assign f_rs  = fd_word[21:17];
    assign f_rt  = fd_word[16:12];
    assign f_br  = (f_opc == `PROC_OP_BNE) || (f_opc == `PROC_OP_BLT);

    always_comb begin
        fd_dec         = '0;
        fd_dec.opcode  = f_opc;
        fd_dec.alu_op  = fd_word[6:2];
        fd_dec.shamt   = fd_word[11:7];
        fd_dec.imm     = {{(`PROC_XLEN-17){fd_word[16]}}, fd_word[16:0]};
        fd_dec.target  = fd_word[26:0];
        fd_dec.ra      = (f_br || f_opc == `PROC_OP_JR) ? f_rd : f_rs;   // Compare / jump reg
        fd_dec.rb      = f_br ? f_rs : (f_opc == `PROC_OP_RTYPE) ? f_rt : f_rd;
        fd_dec.ra_used = f_opc inside {`PROC_OP_RTYPE, `PROC_OP_ADDI, `PROC_OP_LW,
                                       `PROC_OP_SW, `PROC_OP_BNE, `PROC_OP_BLT, `PROC_OP_JR};
        fd_dec.rb_used = f_opc inside {`PROC_OP_RTYPE, `PROC_OP_SW, `PROC_OP_BNE,
                                       `PROC_OP_BLT};
        fd_dec.rd      = (f_opc == `PROC_OP_JAL) ? `PROC_LINK_REG : f_rd;
        // r0 is never a destination, keeps all bypass matches off it
        fd_dec.rd_we   = (f_opc inside {`PROC_OP_RTYPE, `PROC_OP_ADDI, `PROC_OP_LW,
                                        `PROC_OP_JAL}) && fd_dec.rd != '0;
    end

    assign rd_idx_a = fd_dec.ra;
    assign rd_idx_b = fd_dec.rb;

    // Decode/execute register
    always_ff @(posedge clock) begin
        if (rst) begin
            dx.valid <= 1'b0;
        end else if (!hold) begin
            dx.valid <= fd_valid && !load_stall && !redirect_taken;   // Bubble on either
            dx.pc    <= fd_pc;
            dx.dec   <= fd_dec;
            dx.res   <= rd_data_a;   // Raw read A
            dx.sdata <= rd_data_b;   // Raw read B
        end
    end

    assign x_opc   = dx.dec.opcode;
    assign x_rtype = x_opc == `PROC_OP_RTYPE;
    assign x_br    = (x_opc == `PROC_OP_BNE) || (x_opc == `PROC_OP_BLT);

    // Bypass muxes
    always_comb begin
        case (byp_sel.a)
            BYP_MEM: byp_a = xm.res;
            BYP_WB:  byp_a = wr.data;
            default: byp_a = dx.res;
        endcase
        case (byp_sel.b)
            BYP_MEM: byp_b = xm.res;
            BYP_WB:  byp_b = wr.data;
            default: byp_b = dx.sdata;
        endcase
    end

    assign op_a   = (x_opc == `PROC_OP_JAL) ? dx.pc : byp_a;            // Link value base
    assign op_b   = (x_rtype || x_br) ? byp_b :
                    (x_opc == `PROC_OP_JAL) ? `PROC_XLEN'(1) : dx.dec.imm;
    assign alu_op = x_rtype ? dx.dec.alu_op : `PROC_ALU_ADD;            // Address, addi, link

    alu u_alu (
        .op_a      (op_a),
        .op_b      (op_b),
        .alu_op    (alu_op),
        .shamt     (dx.dec.shamt),
        .result    (alu_res),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    // Branch and jump resolution
    always_comb begin
        case (x_opc)
            `PROC_OP_BNE: taken = not_equal;
            `PROC_OP_BLT: taken = less_than;   // rd < rs signed
            `PROC_OP_J, `PROC_OP_JAL, `PROC_OP_JR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
        case (x_opc)
            `PROC_OP_J, `PROC_OP_JAL: redirect_pc = {{(`PROC_XLEN-27){1'b0}}, dx.dec.target};
            `PROC_OP_JR: redirect_pc = byp_a;
            default: redirect_pc = dx.pc + 1'b1 + dx.dec.imm;
        endcase
    end

    assign redirect_taken = dx.valid && taken && !hold;

    // Execute/memory register
    always_ff @(posedge clock) begin
        if (rst) begin
            xm.valid <= 1'b0;
        end else if (!hold) begin
            xm.valid <= dx.valid;
            xm.pc    <= dx.pc;
            xm.dec   <= dx.dec;
            xm.res   <= alu_res;
            xm.sdata <= byp_b;       // sw data from rd
        end
    end

endmodule

`default_nettype wire

//--- hazard_unit.sv
// Pure combinational; loads never bypass from the memory stage so a load-use pair always costs one bubble
`timescale 1ns/1ns
`default_nettype none

`include "proc_macros.svh"

module hazard_unit import proc_pkg::*; (
    input  inst_dec_t fd_dec,
    input  logic      fd_valid,
    input  stage_t    dx,
    input  stage_t    xm,
    input  wr_port_t  wr,
    output logic      load_stall,
    output byp_sel_t  byp_sel
);

    logic dx_is_load;

    // Youngest producer first, r0 never forwarded
    function automatic byp_src_e pick_src(input reg_idx_t src, input logic used,
                                          input stage_t mem, input wr_port_t wb);
        byp_src_e sel;
        sel = BYP_RF;
        if (used && src != '0) begin
            if (mem.valid && mem.dec.rd_we && mem.dec.opcode != `PROC_OP_LW &&
                mem.dec.rd == src) begin
                sel = BYP_MEM;
            end else if (wb.we && wb.idx == src) begin
                sel = BYP_WB;
            end
        end
        return sel;
    endfunction

    assign dx_is_load = dx.valid && dx.dec.opcode == `PROC_OP_LW && dx.dec.rd_we;

    // Load in execute feeding the instruction in decode
    assign load_stall = dx_is_load && fd_valid &&
                        ((fd_dec.ra_used && fd_dec.ra == dx.dec.rd) ||
                         (fd_dec.rb_used && fd_dec.rb == dx.dec.rd));

    always_comb begin
        byp_sel.a = pick_src(dx.dec.ra, dx.dec.ra_used, xm, wr);
        byp_sel.b = pick_src(dx.dec.rb, dx.dec.rb_used, xm, wr);
    end

endmodule

`default_nettype wire

//--- fetch_unit.sv
// PC starts at word 0 after reset; redirect must never be raised together with a memory stall
`timescale 1ns/1ns
`default_nettype none

`include "proc_macros.svh"

module fetch_unit (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  hold,            // load_stall or mem_busy
    input  logic                  redirect_taken,
    input  logic [`PROC_XLEN-1:0] redirect_pc,
    output logic [`PROC_XLEN-1:0] imem_addr,
    input  logic [`PROC_XLEN-1:0] imem_data,
    output logic                  fd_valid,
    output logic [`PROC_XLEN-1:0] fd_pc,
    output logic [`PROC_XLEN-1:0] fd_word
);

    logic [`PROC_XLEN-1:0] pc;

    assign imem_addr = pc;   // Combinational instruction read

    // Program counter
    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;
        end else if (redirect_taken) begin
            pc <= redirect_pc;           // Wins over load_stall
        end else if (!hold) begin
            pc <= pc + 1'b1;             // Word addressed
        end
    end

    // Fetch/decode register
    always_ff @(posedge clock) begin
        if (rst) begin
            fd_valid <= 1'b0;
        end else if (redirect_taken) begin
            fd_valid <= 1'b0;            // Squash the wrong-path fetch
        end else if (!hold) begin
            fd_valid <= 1'b1;
            fd_pc    <= pc;
            fd_word  <= imem_data;
        end
    end

endmodule

`default_nettype wire

//--- regfile.sv
// 32 words, r0 reads zero and ignores writes; contents other than r0 are undefined after reset
`timescale 1ns/1ns
`default_nettype none

`include "proc_macros.svh"

module regfile import proc_pkg::*; (
    input  logic     clock,
    input  logic     rst,
    input  reg_idx_t rd_idx_a,
    input  reg_idx_t rd_idx_b,
    output word_t    rd_data_a,
    output word_t    rd_data_b,
    input  wr_port_t wr
);

    word_t regs [0:(1 << `PROC_REG_W)-1];

    always_ff @(posedge clock) begin
        if (!rst && wr.we && wr.idx != '0) begin
            regs[wr.idx] <= wr.data;
        end
    end

    // Same-cycle write shows through to decode
    assign rd_data_a = (rd_idx_a == '0) ? '0 :
                       (wr.we && wr.idx == rd_idx_a) ? wr.data : regs[rd_idx_a];
    assign rd_data_b = (rd_idx_b == '0) ? '0 :
                       (wr.we && wr.idx == rd_idx_b) ? wr.data : regs[rd_idx_b];

endmodule

`default_nettype wire

//--- alu.sv
// Six integer operations with no overflow flag; flags compare op_a with op_b independently of alu_op
`timescale 1ns/1ns
`default_nettype none

`include "proc_macros.svh"

module alu (
    input  logic [`PROC_XLEN-1:0] op_a,
    input  logic [`PROC_XLEN-1:0] op_b,
    input  logic [4:0]            alu_op,
    input  logic [4:0]            shamt,
    output logic [`PROC_XLEN-1:0] result,
    output logic                  not_equal,
    output logic                  less_than
);

    always_comb begin
        case (alu_op)
            `PROC_ALU_SUB: result = op_a - op_b;
            `PROC_ALU_AND: result = op_a & op_b;
            `PROC_ALU_OR:  result = op_a | op_b;
            `PROC_ALU_SLL: result = op_a << shamt;
            `PROC_ALU_SRA: result = $signed(op_a) >>> shamt;   // Sign fill
            default:       result = op_a + op_b;               // add and unknown codes
        endcase
    end

    assign not_equal = op_a != op_b;
    assign less_than = $signed(op_a) < $signed(op_b);

endmodule

`default_nettype wire

//--- proc_pkg.sv
// Payload types of the pipeline and the Wishbone classic bus; field widths come from proc_macros.svh
`default_nettype none

`include "proc_macros.svh"

package proc_pkg;

    typedef logic [`PROC_XLEN-1:0]  word_t;
    typedef logic [`PROC_REG_W-1:0] reg_idx_t;

    // One decoded instruction
    typedef struct packed {
        logic [4:0]  opcode;    // Opcode class
        logic [4:0]  alu_op;    // R-type only
        logic [4:0]  shamt;
        reg_idx_t    ra;        // Source A, rd for branches and jr
        logic        ra_used;
        reg_idx_t    rb;        // Source B, rd for sw data
        logic        rb_used;
        reg_idx_t    rd;        // Destination, 31 for jal
        logic        rd_we;     // Never set for r0
        word_t       imm;       // Sign-extended 17-bit immediate
        logic [26:0] target;    // j / jal target
    } inst_dec_t;

    // Stage register payload
    // In decode/execute res and sdata hold the raw register reads A and B
    typedef struct packed {
        logic      valid;
        word_t     pc;
        inst_dec_t dec;
        word_t     res;         // ALU result or address
        word_t     sdata;       // Store data
    } stage_t;

    // Operand source choice in execute
    typedef enum logic [1:0] {
        BYP_RF  = 2'd0,
        BYP_MEM = 2'd1,         // Result in execute/memory
        BYP_WB  = 2'd2          // Write port data
    } byp_src_e;

    typedef struct packed {
        byp_src_e a;
        byp_src_e b;
    } byp_sel_t;

    // Wishbone classic master outputs
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;
        word_t dat;
    } wb_req_t;

    // Wishbone classic slave outputs
    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    // Register file write port, also the writeback bypass source
    typedef struct packed {
        logic     we;
        reg_idx_t idx;
        word_t    data;
    } wr_port_t;

endpackage

`default_nettype wire

//--- proc_macros.svh
// Widths and encodings shared by the core; opcode and ALU-op values follow the 32-bit ISA, mul/div codes are absent
`ifndef PROC_MACROS_SVH
`define PROC_MACROS_SVH

// Datapath widths
`define PROC_XLEN       32      // Data and word-address width
`define PROC_REG_W      5       // Register index width
`define PROC_LINK_REG   5'd31   // jal destination

// Instruction opcodes, bits [31:27]
`define PROC_OP_RTYPE   5'b00000
`define PROC_OP_J       5'b00001
`define PROC_OP_BNE     5'b00010
`define PROC_OP_JAL     5'b00011
`define PROC_OP_JR      5'b00100
`define PROC_OP_ADDI    5'b00101
`define PROC_OP_BLT     5'b00110
`define PROC_OP_SW      5'b00111
`define PROC_OP_LW      5'b01000

// R-type ALU operation field, bits [6:2]
`define PROC_ALU_ADD    5'b00000
`define PROC_ALU_SUB    5'b00001
`define PROC_ALU_AND    5'b00010
`define PROC_ALU_OR     5'b00011
`define PROC_ALU_SLL    5'b00100
`define PROC_ALU_SRA    5'b00101

`endif
